// File: hw/adc_emu_pkg.sv
`default_nettype none

package adc_emu_pkg;

    ////////////////////
    // widths
    ////////////////////

    // signed input voltage code
    parameter int VIN_WIDTH = 16;

    // magnitude part of the quantizer output
    parameter int ADC_WIDTH = 8;

    // sampling clock divider, 2^DIV_WIDTH clk_in periods per sample
    parameter int DIV_WIDTH = 2;

    ////////////////////
    // vector types
    ////////////////////

    typedef logic signed [VIN_WIDTH-1:0] vin_t;
    typedef logic [ADC_WIDTH-1:0] mag_t;
    typedef logic [DIV_WIDTH-1:0] div_t;

    ////////////////////
    // sync chain states
    ////////////////////

    // encoded as {presented output, sampled request}
    typedef enum logic [1:0] {
        SYNC_OFF   = 2'b00,
        SYNC_ARMED = 2'b01,
        SYNC_RUN   = 2'b11,
        SYNC_DRAIN = 2'b10
    } sync_state_t;

endpackage

`default_nettype wire

// File: hw/slice_timing_if.sv
`timescale 1ns/1ps
`default_nettype none

interface slice_timing_if;

    // clk_in edge strobes, one emu_clk cycle each
    logic edge_p;
    logic edge_n;

    // sampled sync request, gated by the slice enable
    logic en_sync;

    // one pulse per divided clock period
    logic sample_strobe;

    modport detector (output edge_p, output edge_n);

    modport sync (input edge_p, input edge_n, output en_sync);

    modport divider (input edge_n, input en_sync, output sample_strobe);

    modport quant (input sample_strobe);

endinterface

`default_nettype wire

// File: hw/clk_edge_detect.sv
`timescale 1ns/1ps
`default_nettype none

module clk_edge_detect (
    input  logic                    emu_clk,
    input  logic                    reset,
    input  logic                    clk_in,
    slice_timing_if.detector        tmg
);

    // clk_in history, stage 0 is the newest sample
    logic clk_in_s0;
    logic clk_in_s1;

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            clk_in_s0 <= 1'b0;
            clk_in_s1 <= 1'b0;
        end else begin
            clk_in_s0 <= clk_in;
            clk_in_s1 <= clk_in_s0;
        end
    end

    // strobes are registered, so they show two cycles after sampling
    always_ff @(posedge emu_clk) begin
        if (reset) begin
            tmg.edge_p <= 1'b0;
            tmg.edge_n <= 1'b0;
        end else begin
            tmg.edge_p <= clk_in_s0 & ~clk_in_s1;
            tmg.edge_n <= ~clk_in_s0 & clk_in_s1;
        end
    end

endmodule

`default_nettype wire

// File: hw/slice_sync_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module slice_sync_fsm
    import adc_emu_pkg::*;
(
    input  logic                    emu_clk,
    input  logic                    reset,
    input  logic                    en_sync_in,
    input  logic                    en_slice,
    output logic                    en_sync_out,
    slice_timing_if.sync            tmg
);

    sync_state_t state_q;
    sync_state_t state_d;

    // flags carried in the state
    logic sampled_q;
    logic out_d;

    ////////////////////
    // next state
    ////////////////////

    // falling edge samples the request, rising edge presents it
    always_comb begin
        state_d = state_q;
        case (state_q)
            SYNC_OFF: begin
                if (tmg.edge_n && en_sync_in) begin
                    state_d = SYNC_ARMED;
                end
            end
            SYNC_ARMED: begin
                if (tmg.edge_n && !en_sync_in) begin
                    state_d = SYNC_OFF;
                end else if (tmg.edge_p) begin
                    state_d = SYNC_RUN;
                end
            end
            SYNC_RUN: begin
                if (tmg.edge_n && !en_sync_in) begin
                    state_d = SYNC_DRAIN;
                end
            end
            SYNC_DRAIN: begin
                // request came back before the output dropped
                if (tmg.edge_n && en_sync_in) begin
                    state_d = SYNC_RUN;
                end else if (tmg.edge_p) begin
                    state_d = SYNC_OFF;
                end
            end
            default: state_d = SYNC_OFF;
        endcase
    end

    assign out_d = (state_d == SYNC_RUN) || (state_d == SYNC_DRAIN);
    assign sampled_q = (state_q == SYNC_ARMED) || (state_q == SYNC_RUN);

    ////////////////////
    // state and output
    ////////////////////

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            state_q     <= SYNC_OFF;
            en_sync_out <= 1'b0;
        end else begin
            state_q     <= state_d;
            en_sync_out <= out_d;
        end
    end

    // divider only runs while this slice is enabled
    assign tmg.en_sync = sampled_q & en_slice;

endmodule

`default_nettype wire

// File: hw/sample_divider.sv
`timescale 1ns/1ps
`default_nettype none

module sample_divider
    import adc_emu_pkg::*;
#(
    parameter int DIV_WIDTH = adc_emu_pkg::DIV_WIDTH
) (
    input  logic                    emu_clk,
    input  logic                    reset,
    input  div_t                    init,
    input  logic                    alws_on,
    output logic                    clk_adder,
    slice_timing_if.divider         tmg
);

    logic [DIV_WIDTH-1:0] count_q;
    logic                 clk_adder_q;
    logic                 clk_adder_d1;

    ////////////////////
    // phase counter
    ////////////////////

    // idle slice sits at its start phase, always-on parks at all ones
    always_ff @(posedge emu_clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (!tmg.en_sync) begin
            count_q <= DIV_WIDTH'(init);
        end else if (alws_on) begin
            count_q <= '1;
        end else if (tmg.edge_n) begin
            count_q <= count_q + 1'b1;
        end
    end

    ////////////////////
    // divided clock
    ////////////////////

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            clk_adder_q  <= 1'b1;
            clk_adder_d1 <= 1'b1;
        end else begin
            clk_adder_q  <= ~count_q[DIV_WIDTH-1];
            clk_adder_d1 <= clk_adder_q;
        end
    end

    assign clk_adder = clk_adder_q;

    // rising edge of clk_adder
    assign tmg.sample_strobe = clk_adder_q & ~clk_adder_d1;

endmodule

`default_nettype wire

// File: hw/adc_quantizer.sv
`timescale 1ns/1ps
`default_nettype none

module adc_quantizer
    import adc_emu_pkg::*;
#(
    parameter int VIN_WIDTH = adc_emu_pkg::VIN_WIDTH,
    parameter int ADC_WIDTH = adc_emu_pkg::ADC_WIDTH
) (
    input  logic                    emu_clk,
    input  logic                    reset,
    input  vin_t                    vin,
    output logic                    sign_out,
    output mag_t                    adder_out,
    output logic                    sample_valid,
    slice_timing_if.quant           tmg
);

    // drop the sign bit and the bits below the output resolution
    localparam int SHIFT = VIN_WIDTH - 1 - ADC_WIDTH;

    logic [VIN_WIDTH-1:0] vin_bits;
    logic [VIN_WIDTH-1:0] vin_abs;
    logic [VIN_WIDTH-1:0] vin_shift;
    logic                 sign_d;
    logic                 sat;
    logic [ADC_WIDTH-1:0] mag_d;
    logic [ADC_WIDTH-1:0] mag_q;

    ////////////////////
    // sign and magnitude
    ////////////////////

    assign vin_bits = VIN_WIDTH'(vin);
    assign sign_d   = vin_bits[VIN_WIDTH-1];

    // two's complement negate, the most negative code maps to 2^(VIN_WIDTH-1)
    assign vin_abs = sign_d ? (~vin_bits + 1'b1) : vin_bits;

    assign vin_shift = vin_abs >> SHIFT;

    // anything above the output range clips to full scale
    assign sat = |vin_shift[VIN_WIDTH-1:ADC_WIDTH];

    always_comb begin
        if (sat) begin
            mag_d = '1;
        end else begin
            mag_d = vin_shift[ADC_WIDTH-1:0];
        end
    end

    ////////////////////
    // result registers
    ////////////////////

    // result holds until the next strobe overwrites it
    always_ff @(posedge emu_clk) begin
        if (reset) begin
            sign_out <= 1'b0;
            mag_q    <= '0;
        end else if (tmg.sample_strobe) begin
            sign_out <= sign_d;
            mag_q    <= mag_d;
        end
    end

    // one pulse per new result
    always_ff @(posedge emu_clk) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= tmg.sample_strobe;
        end
    end

    assign adder_out = mag_t'(mag_q);

endmodule

`default_nettype wire

// File: hw/adc_slice_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_slice_top
    import adc_emu_pkg::*;
#(
    parameter int VIN_WIDTH = adc_emu_pkg::VIN_WIDTH,
    parameter int ADC_WIDTH = adc_emu_pkg::ADC_WIDTH,
    parameter int DIV_WIDTH = adc_emu_pkg::DIV_WIDTH
) (
    input  logic                    emu_clk,
    input  logic                    reset,

    // modelled sampling clock and enables
    input  logic                    clk_in,
    input  logic                    en_slice,
    input  logic                    en_sync_in,
    input  logic                    alws_on,
    input  div_t                    init,

    input  vin_t                    vin,

    output logic                    clk_adder,
    output logic                    en_sync_out,
    output logic                    sign_out,
    output mag_t                    adder_out,
    output logic                    sample_valid
);

    slice_timing_if tmg ();

    ////////////////////
    // clk_in edges
    ////////////////////

    clk_edge_detect i_clk_edge_detect (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .clk_in      (clk_in),
        .tmg         (tmg.detector)
    );

    ////////////////////
    // sync chain
    ////////////////////

    slice_sync_fsm i_slice_sync_fsm (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .en_sync_in  (en_sync_in),
        .en_slice    (en_slice),
        .en_sync_out (en_sync_out),
        .tmg         (tmg.sync)
    );

    // divided sampling clock
    sample_divider #(
        .DIV_WIDTH   (DIV_WIDTH)
    ) i_sample_divider (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .init        (init),
        .alws_on     (alws_on),
        .clk_adder   (clk_adder),
        .tmg         (tmg.divider)
    );

    ////////////////////
    // quantizer
    ////////////////////

    adc_quantizer #(
        .VIN_WIDTH   (VIN_WIDTH),
        .ADC_WIDTH   (ADC_WIDTH)
    ) i_adc_quantizer (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .vin         (vin),
        .sign_out    (sign_out),
        .adder_out   (adder_out),
        .sample_valid(sample_valid),
        .tmg         (tmg.quant)
    );

endmodule

`default_nettype wire

// File: dv/adc_slice_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adc_slice_tb
    import adc_emu_pkg::*;
();

    localparam int VIN_W = VIN_WIDTH;
    localparam int ADC_W = ADC_WIDTH;
    localparam int DIV_W = DIV_WIDTH;
    localparam int SHIFT = VIN_W - 1 - ADC_W;
    localparam int DIV_PERIOD = 1 << DIV_W;
    localparam int LEVEL_CYCLES = 4;
    localparam int CLK_IN_NS = 2 * LEVEL_CYCLES * 4;
    localparam int FIXED_ROWS = 10;
    localparam int ROWS = FIXED_ROWS + 14;
    localparam int WATCHDOG_NS = ROWS * DIV_PERIOD * CLK_IN_NS * 4;
    // two divided periods at most per sample
    localparam int SAMPLE_WAIT = 2 * DIV_PERIOD * 2 * LEVEL_CYCLES;

    logic emu_clk = 1'b0;
    logic reset;
    logic clk_in;
    logic en_slice;
    logic en_sync_in;
    logic alws_on;
    logic [DIV_W-1:0] init;
    logic signed [VIN_W-1:0] vin;
    logic clk_adder;
    logic en_sync_out;
    logic sign_out;
    logic [ADC_W-1:0] adder_out;
    logic sample_valid;

    // stimulus table with expected results
    logic signed [VIN_W-1:0] tbl_vin [ROWS];
    logic tbl_sign [ROWS];
    logic [ADC_W-1:0] tbl_mag [ROWS];

    // clk_in generator state
    logic clk_run;
    int rise_count;
    int fall_count;
    logic sync_sampled;
    int sync_errs;
    int sync_checks;

    // falling edge index of every sample_valid pulse
    int pulse_falls[$];

    int err_count;
    int check_count;
    logic [31:0] lcg_state;

    adc_slice_top #(
        .VIN_WIDTH   (VIN_W),
        .ADC_WIDTH   (ADC_W),
        .DIV_WIDTH   (DIV_W)
    ) i_adc_slice_top (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .clk_in      (clk_in),
        .en_slice    (en_slice),
        .en_sync_in  (en_sync_in),
        .alws_on     (alws_on),
        .init        (init),
        .vin         (vin),
        .clk_adder   (clk_adder),
        .en_sync_out (en_sync_out),
        .sign_out    (sign_out),
        .adder_out   (adder_out),
        .sample_valid(sample_valid)
    );

    always #2 emu_clk = ~emu_clk;

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // returns {sign, magnitude}
    function automatic logic [ADC_W:0] quant_ref(input logic signed [VIN_W-1:0] v);
        longint mag;
        logic sgn;
        sgn = (v < 0);
        mag = longint'(v);
        if (sgn) begin
            mag = -mag;
        end
        mag = mag >> SHIFT;
        // clip to full scale
        if (mag > (longint'(1) << ADC_W) - 1) begin
            mag = (longint'(1) << ADC_W) - 1;
        end
        return {sgn, mag[ADC_W-1:0]};
    endfunction

    task automatic build_table();
        logic [ADC_W:0] ref_val;
        int i;
        tbl_vin[0] = '0;
        tbl_vin[1] = VIN_W'(1);
        tbl_vin[2] = VIN_W'((1 << SHIFT) - 1);
        tbl_vin[3] = VIN_W'(1 << SHIFT);
        tbl_vin[4] = VIN_W'(-(1 << SHIFT));
        tbl_vin[5] = VIN_W'(-1);
        tbl_vin[6] = {1'b0, {(VIN_W-1){1'b1}}};
        tbl_vin[7] = {1'b1, {(VIN_W-1){1'b0}}};
        tbl_vin[8] = {1'b1, {(VIN_W-2){1'b0}}, 1'b1};
        tbl_vin[9] = VIN_W'(32'h1234);
        for (i = FIXED_ROWS; i < ROWS; i++) begin
            lcg_state = lcg_next(lcg_state);
            tbl_vin[i] = VIN_W'(lcg_state >> 16);
        end
        for (i = 0; i < ROWS; i++) begin
            ref_val = quant_ref(tbl_vin[i]);
            tbl_sign[i] = ref_val[ADC_W];
            tbl_mag[i] = ref_val[ADC_W-1:0];
        end
    endtask

    ////////////////////
    // clk_in and timing
    ////////////////////

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge emu_clk);
            #1;
        end
    endtask

    // en_sync_out checked at the end of the high level
    task automatic clk_in_period();
        clk_in = 1'b1;
        rise_count++;
        step_cycles(LEVEL_CYCLES);
        sync_checks++;
        if (en_sync_out !== sync_sampled) begin
            sync_errs++;
            $display("ERR en_sync_out: got 0x%0h, expected 0x%0h", en_sync_out, sync_sampled);
        end
        clk_in = 1'b0;
        sync_sampled = en_sync_in;
        fall_count++;
        step_cycles(LEVEL_CYCLES);
    endtask

    // returns one cycle into the high level of clk_in
    task automatic wait_rises(input int n);
        int target;
        @(negedge emu_clk);
        target = rise_count + n;
        while (rise_count < target) begin
            @(negedge emu_clk);
        end
        step_cycles(1);
    endtask

    initial begin : clk_in_gen
        wait (clk_run);
        forever begin
            clk_in_period();
        end
    end

    always @(negedge emu_clk) begin
        if (!reset && sample_valid) begin
            pulse_falls.push_back(fall_count);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin : main
        int r;
        int p;
        int k0;
        int base;
        int waited;
        logic [7:0] sync_pattern;
        reset = 1'b1;
        clk_in = 1'b0;
        en_slice = 1'b0;
        en_sync_in = 1'b0;
        alws_on = 1'b0;
        init = '0;
        vin = '0;
        clk_run = 1'b0;
        rise_count = 0;
        fall_count = 0;
        sync_sampled = 1'b0;
        sync_errs = 0;
        sync_checks = 0;
        err_count = 0;
        check_count = 0;
        lcg_state = 32'h35a4;
        sync_pattern = 8'b1011_0010;
        build_table();

        repeat (10) @(posedge emu_clk);
        #1;
        reset = 1'b0;
        step_cycles(1);

        // values right after reset
        check_count += 5;
        if (en_sync_out !== 1'b0) begin
            err_count++;
            $display("ERR en_sync_out: got 0x%0h, expected 0x0", en_sync_out);
        end
        if (sample_valid !== 1'b0) begin
            err_count++;
            $display("ERR sample_valid: got 0x%0h, expected 0x0", sample_valid);
        end
        if (sign_out !== 1'b0) begin
            err_count++;
            $display("ERR sign_out: got 0x%0h, expected 0x0", sign_out);
        end
        if (adder_out !== '0) begin
            err_count++;
            $display("ERR adder_out: got 0x%0h, expected 0x0", adder_out);
        end
        if (clk_adder !== 1'b1) begin
            err_count++;
            $display("ERR clk_adder: got 0x%0h, expected 0x1", clk_adder);
        end

        // sync chain, one request change per clk_in period
        en_slice = 1'b1;
        clk_run = 1'b1;
        for (r = 0; r < 8; r++) begin
            wait_rises(1);
            en_sync_in = sync_pattern[r];
        end

        // divider phase for two start values
        for (p = 0; p < 2; p++) begin
            wait_rises(1);
            en_sync_in = 1'b0;
            init = (p == 0) ? {DIV_W{1'b0}} : {DIV_W{1'b1}};
            wait_rises(2);
            en_sync_in = 1'b1;
            k0 = fall_count + 1;
            base = pulse_falls.size();
            wait_rises(2 * DIV_PERIOD + 1);
            step_cycles(LEVEL_CYCLES);
            check_count++;
            if (pulse_falls.size() - base != 2) begin
                err_count++;
                $display("init %0d gave %0d sample pulses over %0d falling edges, expected 2",
                         init, pulse_falls.size() - base, 2 * DIV_PERIOD);
            end else begin
                check_count += 2;
                if (pulse_falls[base+1] - pulse_falls[base] != DIV_PERIOD) begin
                    err_count++;
                    $display("sample pulses for init %0d are not %0d falling edges apart",
                             init, DIV_PERIOD);
                end
                if ((pulse_falls[base] - k0 + int'(init)) % DIV_PERIOD != 0) begin
                    err_count++;
                    $display("sample pulse at falling edge %0d is off phase for init %0d",
                             pulse_falls[base], init);
                end
            end
        end

        // quantizer table, vin held until a fresh sample
        for (r = 0; r < ROWS; r++) begin
            vin = tbl_vin[r];
            waited = 0;
            step_cycles(1);
            while (!sample_valid && waited < SAMPLE_WAIT) begin
                step_cycles(1);
                waited++;
            end
            if (!sample_valid) begin
                err_count++;
                $display("no sample_valid within %0d cycles for row %0d", SAMPLE_WAIT, r);
            end else begin
                check_count += 2;
                if (sign_out !== tbl_sign[r]) begin
                    err_count++;
                    $display("ERR sign_out: got 0x%0h, expected 0x%0h (vin 0x%0h)",
                             sign_out, tbl_sign[r], tbl_vin[r]);
                end
                if (adder_out !== tbl_mag[r]) begin
                    err_count++;
                    $display("ERR adder_out: got 0x%0h, expected 0x%0h (vin 0x%0h)",
                             adder_out, tbl_mag[r], tbl_vin[r]);
                end
            end
        end

        // always-on first, then slice disabled with the sync chain still toggling
        for (p = 0; p < 2; p++) begin
            wait_rises(1);
            alws_on = (p == 0);
            en_slice = (p == 0);
            wait_rises(1);
            base = pulse_falls.size();
            for (r = 0; r < 16; r++) begin
                wait_rises(1);
                en_sync_in = (p == 0) ? 1'b1 : r[1];
            end
            step_cycles(LEVEL_CYCLES);
            check_count += 3;
            if (pulse_falls.size() != base) begin
                err_count++;
                $display("%0d sample pulses while the divider should be stopped (pass %0d)",
                         pulse_falls.size() - base, p);
            end
            if (sign_out !== tbl_sign[ROWS-1]) begin
                err_count++;
                $display("ERR sign_out: got 0x%0h, expected 0x%0h", sign_out, tbl_sign[ROWS-1]);
            end
            if (adder_out !== tbl_mag[ROWS-1]) begin
                err_count++;
                $display("ERR adder_out: got 0x%0h, expected 0x%0h", adder_out, tbl_mag[ROWS-1]);
            end
        end

        err_count += sync_errs;
        check_count += sync_checks;
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hw/adc_emu_pkg.sv
hw/slice_timing_if.sv
hw/clk_edge_detect.sv
hw/slice_sync_fsm.sv
hw/sample_divider.sv
hw/adc_quantizer.sv
hw/adc_slice_top.sv
dv/adc_slice_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ADC slice testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f project.f \
    --top-module adc_slice_tb \
    --Mdir obj_dir \
    -o adc_slice_sim

# the simulation log decides pass or fail
./obj_dir/adc_slice_sim > sim.log 2>&1
cat sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
